/* rtl/csr_defs.svh */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

`define CSR_NUM_W           14
`define CSR_DATA_W          32

// Register numbers
`define CSR_CRMD            14'h000
`define CSR_PRMD            14'h001
`define CSR_ECFG            14'h004
`define CSR_ESTAT           14'h005
`define CSR_ERA             14'h006
`define CSR_BADV            14'h007
`define CSR_EENTRY          14'h00c
`define CSR_SAVE0           14'h030
`define CSR_SAVE1           14'h031
`define CSR_SAVE2           14'h032
`define CSR_SAVE3           14'h033
`define CSR_TCFG            14'h041
`define CSR_TVAL            14'h042
`define CSR_TICLR           14'h044

// Field positions
`define CSR_CRMD_PLV        1:0
`define CSR_CRMD_IE         2
`define CSR_PRMD_PPLV       1:0
`define CSR_PRMD_PIE        2
`define CSR_ECFG_LIE        12:0
`define CSR_ESTAT_IS10      1:0
`define CSR_ESTAT_IS        12:0
`define CSR_ESTAT_ECODE     21:16
`define CSR_ESTAT_ESUBCODE  30:22
`define CSR_ERA_PC          31:0
`define CSR_BADV_VADDR      31:0
`define CSR_EENTRY_VA       31:6
`define CSR_SAVE_DATA       31:0
`define CSR_TCFG_EN         0
`define CSR_TCFG_PERIODIC   1
`define CSR_TCFG_INITVAL    31:2
`define CSR_TVAL_TIMEVAL    31:0
`define CSR_TICLR_CLR       0

`endif

/* rtl/csr_pkg.sv */
`include "csr_defs.svh"

package csr_pkg;

  // SAVE0..SAVE3 must stay consecutive
  typedef enum logic [4:0] {
    CSR_NONE,
    CSR_CRMD,
    CSR_PRMD,
    CSR_ECFG,
    CSR_ESTAT,
    CSR_ERA,
    CSR_BADV,
    CSR_EENTRY,
    CSR_SAVE0,
    CSR_SAVE1,
    CSR_SAVE2,
    CSR_SAVE3,
    CSR_TCFG,
    CSR_TVAL,
    CSR_TICLR
  } csr_reg_e;

  typedef enum logic [5:0] {
    ECODE_INT = 6'h00,
    ECODE_ADE = 6'h08,
    ECODE_ALE = 6'h09,
    ECODE_SYS = 6'h0b,
    ECODE_BRK = 6'h0c,
    ECODE_INE = 6'h0d
  } ecode_e;

  localparam logic [8:0] ESUBCODE_ADEF = 9'd0;

  typedef struct packed {
    logic                   en;
    csr_reg_e               sel;
    logic [`CSR_DATA_W-1:0] wmask;
    logic [`CSR_DATA_W-1:0] wvalue;
  } csr_write_t;

  // One writeback-stage event
  typedef struct packed {
    logic                   ex;
    logic                   eret;
    ecode_e                 ecode;
    logic [8:0]             esubcode;
    logic [`CSR_DATA_W-1:0] pc;
    logic [`CSR_DATA_W-1:0] vaddr;
  } exc_info_t;

  function automatic logic [`CSR_DATA_W-1:0] masked_merge(
    input logic [`CSR_DATA_W-1:0] old_val,
    input logic [`CSR_DATA_W-1:0] wmask,
    input logic [`CSR_DATA_W-1:0] wvalue
  );
    return (wmask & wvalue) | (~wmask & old_val);
  endfunction

endpackage

/* rtl/csr_decode.sv */
`include "csr_defs.svh"

module csr_decode import csr_pkg::*; (
  input  logic [`CSR_NUM_W-1:0]  csr_num,
  input  logic                   csr_we,
  input  logic [`CSR_DATA_W-1:0] csr_wmask,
  input  logic [`CSR_DATA_W-1:0] csr_wvalue,
  output csr_write_t             wr,
  output csr_reg_e               rd_sel
);

  csr_reg_e sel;

  // Architectural number to register name
  always_comb begin
    case (csr_num)
      `CSR_CRMD:   sel = CSR_CRMD;
      `CSR_PRMD:   sel = CSR_PRMD;
      `CSR_ECFG:   sel = CSR_ECFG;
      `CSR_ESTAT:  sel = CSR_ESTAT;
      `CSR_ERA:    sel = CSR_ERA;
      `CSR_BADV:   sel = CSR_BADV;
      `CSR_EENTRY: sel = CSR_EENTRY;
      `CSR_SAVE0:  sel = CSR_SAVE0;
      `CSR_SAVE1:  sel = CSR_SAVE1;
      `CSR_SAVE2:  sel = CSR_SAVE2;
      `CSR_SAVE3:  sel = CSR_SAVE3;
      `CSR_TCFG:   sel = CSR_TCFG;
      `CSR_TVAL:   sel = CSR_TVAL;
      `CSR_TICLR:  sel = CSR_TICLR;
      default:     sel = CSR_NONE;
    endcase
  end

  // Writes to unknown numbers are dropped here
  always_comb begin
    wr.en     = csr_we && (sel != CSR_NONE);
    wr.sel    = sel;
    wr.wmask  = csr_wmask;
    wr.wvalue = csr_wvalue;
  end

  assign rd_sel = sel;

endmodule

/* rtl/csr_exc_regs.sv */
`include "csr_defs.svh"

module csr_exc_regs import csr_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  csr_write_t                   wr,
  input  exc_info_t                    exc,
  input  logic [7:0]                   hw_int,
  input  logic                         timer_is,
  output logic [1:0]                   plv,
  output logic [1:0]                   pplv,
  output logic                         ie,
  output logic                         pie,
  output logic [12:0]                  lie,
  output logic [12:0]                  is_out,
  output ecode_e                       ecode,
  output logic [8:0]                   esubcode,
  output logic [`CSR_DATA_W-1:0]       era,
  output logic [`CSR_DATA_W-1:0]       badv,
  output logic [25:0]                  eentry_va,
  output logic [3:0][`CSR_DATA_W-1:0]  save,
  output logic                         has_int
);

  logic [1:0]             sw_is;
  logic [7:0]             hw_is;
  logic                   addr_err;
  logic [`CSR_DATA_W-1:0] crmd_next;
  logic [`CSR_DATA_W-1:0] prmd_next;
  logic [`CSR_DATA_W-1:0] ecfg_next;
  logic [`CSR_DATA_W-1:0] estat_next;
  logic [`CSR_DATA_W-1:0] era_next;
  logic [`CSR_DATA_W-1:0] badv_next;
  logic [`CSR_DATA_W-1:0] eentry_next;

  assign crmd_next   = masked_merge({29'b0, ie, plv}, wr.wmask, wr.wvalue);
  assign prmd_next   = masked_merge({29'b0, pie, pplv}, wr.wmask, wr.wvalue);
  assign ecfg_next   = masked_merge({19'b0, lie}, wr.wmask, wr.wvalue);
  assign estat_next  = masked_merge({30'b0, sw_is}, wr.wmask, wr.wvalue);
  assign era_next    = masked_merge(era, wr.wmask, wr.wvalue);
  assign badv_next   = masked_merge(badv, wr.wmask, wr.wvalue);
  assign eentry_next = masked_merge({eentry_va, 6'b0}, wr.wmask, wr.wvalue);

  always_ff @(posedge clk) begin
    if (reset) begin
      plv <= 2'b0;
      ie  <= 1'b0;
    end else if (exc.ex) begin
      plv <= 2'b0;
      ie  <= 1'b0;
    end else if (exc.eret) begin
      plv <= pplv;
      ie  <= pie;
    end else if (wr.en && wr.sel == CSR_CRMD) begin
      plv <= crmd_next[`CSR_CRMD_PLV];
      ie  <= crmd_next[`CSR_CRMD_IE];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pplv <= 2'b0;
      pie  <= 1'b0;
    end else if (exc.ex) begin
      pplv <= plv;
      pie  <= ie;
    end else if (wr.en && wr.sel == CSR_PRMD) begin
      pplv <= prmd_next[`CSR_PRMD_PPLV];
      pie  <= prmd_next[`CSR_PRMD_PIE];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lie   <= 13'b0;
      sw_is <= 2'b0;
      hw_is <= 8'b0;
    end else begin
      hw_is <= hw_int;
      if (wr.en && wr.sel == CSR_ECFG)
        lie <= ecfg_next[`CSR_ECFG_LIE];
      if (wr.en && wr.sel == CSR_ESTAT)
        sw_is <= estat_next[`CSR_ESTAT_IS10];
    end
  end

  // Exception cause fields
  always_ff @(posedge clk) begin
    if (reset) begin
      ecode    <= ECODE_INT;
      esubcode <= 9'b0;
    end else if (exc.ex) begin
      ecode    <= exc.ecode;
      esubcode <= exc.esubcode;
    end
  end

  assign addr_err = (exc.ecode == ECODE_ADE) || (exc.ecode == ECODE_ALE);

  always_ff @(posedge clk) begin
    if (exc.ex) begin
      era <= exc.pc;
      if (addr_err) begin
        // Fetch faults report the pc itself
        if (exc.ecode == ECODE_ADE && exc.esubcode == ESUBCODE_ADEF)
          badv <= exc.pc;
        else
          badv <= exc.vaddr;
      end
    end else begin
      if (wr.en && wr.sel == CSR_ERA)
        era <= era_next[`CSR_ERA_PC];
      if (wr.en && wr.sel == CSR_BADV)
        badv <= badv_next[`CSR_BADV_VADDR];
    end
  end

  always_ff @(posedge clk) begin
    if (wr.en && wr.sel == CSR_EENTRY)
      eentry_va <= eentry_next[`CSR_EENTRY_VA];
  end

  for (genvar i = 0; i < 4; i++) begin : g_save
    logic [`CSR_DATA_W-1:0] save_next;

    assign save_next = masked_merge(save[i], wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
      if (wr.en && wr.sel == csr_reg_e'(5'(CSR_SAVE0) + 5'(i)))
        save[i] <= save_next[`CSR_SAVE_DATA];
    end
  end

  // IPI line and bit 12 tie to zero
  assign is_out  = {1'b0, timer_is, 1'b0, hw_is, sw_is};
  assign has_int = (|(is_out[11:0] & lie[11:0])) && ie;

  a_ex_eret_excl: assert property (@(posedge clk) disable iff (reset)
    !(exc.ex && exc.eret));

endmodule

/* rtl/csr_timer.sv */
`include "csr_defs.svh"

module csr_timer import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  csr_write_t             wr,
  output logic                   tcfg_en,
  output logic                   tcfg_periodic,
  output logic [29:0]            tcfg_initval,
  output logic [`CSR_DATA_W-1:0] tval,
  output logic                   timer_is
);

  logic                   we_tcfg;
  logic                   ticlr;
  logic [`CSR_DATA_W-1:0] tcfg_next;

  assign we_tcfg   = wr.en && wr.sel == CSR_TCFG;
  assign ticlr     = wr.en && wr.sel == CSR_TICLR &&
                     wr.wmask[`CSR_TICLR_CLR] && wr.wvalue[`CSR_TICLR_CLR];
  assign tcfg_next = masked_merge({tcfg_initval, tcfg_periodic, tcfg_en},
                                  wr.wmask, wr.wvalue);

  always_ff @(posedge clk) begin
    if (reset)
      tcfg_en <= 1'b0;
    else if (we_tcfg)
      tcfg_en <= tcfg_next[`CSR_TCFG_EN];
  end

  always_ff @(posedge clk) begin
    if (we_tcfg) begin
      tcfg_periodic <= tcfg_next[`CSR_TCFG_PERIODIC];
      tcfg_initval  <= tcfg_next[`CSR_TCFG_INITVAL];
    end
  end

  // All-ones means stopped
  always_ff @(posedge clk) begin
    if (reset)
      tval <= '1;
    else if (we_tcfg && tcfg_next[`CSR_TCFG_EN])
      tval <= {tcfg_next[`CSR_TCFG_INITVAL], 2'b0};
    else if (tcfg_en && tval != '1) begin
      if (tval == '0 && tcfg_periodic)
        tval <= {tcfg_initval, 2'b0};
      else
        tval <= tval - 1'b1;
    end
  end

  // Set has priority over a same-cycle clear
  always_ff @(posedge clk) begin
    if (reset)
      timer_is <= 1'b0;
    else if (tcfg_en && tval == '0)
      timer_is <= 1'b1;
    else if (ticlr)
      timer_is <= 1'b0;
  end

  a_cnt_frozen: assert property (@(posedge clk) disable iff (reset)
    !tcfg_en && !we_tcfg |=> $stable(tval));

  a_is_after_zero: assert property (@(posedge clk) disable iff (reset)
    $rose(timer_is) |-> $past(tcfg_en && tval == '0));

endmodule

/* rtl/csr_read_mux.sv */
`include "csr_defs.svh"

module csr_read_mux import csr_pkg::*; (
  input  csr_reg_e                     rd_sel,
  input  logic [1:0]                   plv,
  input  logic [1:0]                   pplv,
  input  logic                         ie,
  input  logic                         pie,
  input  logic [12:0]                  lie,
  input  logic [12:0]                  estat_is,
  input  ecode_e                       ecode,
  input  logic [8:0]                   esubcode,
  input  logic [`CSR_DATA_W-1:0]       era,
  input  logic [`CSR_DATA_W-1:0]       badv,
  input  logic [25:0]                  eentry_va,
  input  logic [3:0][`CSR_DATA_W-1:0]  save,
  input  logic                         tcfg_en,
  input  logic                         tcfg_periodic,
  input  logic [29:0]                  tcfg_initval,
  input  logic [`CSR_DATA_W-1:0]       tval,
  output logic [`CSR_DATA_W-1:0]       csr_rvalue
);

  logic [`CSR_DATA_W-1:0] crmd_val;
  logic [`CSR_DATA_W-1:0] prmd_val;
  logic [`CSR_DATA_W-1:0] ecfg_val;
  logic [`CSR_DATA_W-1:0] estat_val;
  logic [`CSR_DATA_W-1:0] eentry_val;
  logic [`CSR_DATA_W-1:0] tcfg_val;

  // Reserved bits stay zero
  always_comb begin
    crmd_val   = '0;
    prmd_val   = '0;
    ecfg_val   = '0;
    estat_val  = '0;
    eentry_val = '0;
    tcfg_val   = '0;
    crmd_val[`CSR_CRMD_PLV]         = plv;
    crmd_val[`CSR_CRMD_IE]          = ie;
    prmd_val[`CSR_PRMD_PPLV]        = pplv;
    prmd_val[`CSR_PRMD_PIE]         = pie;
    ecfg_val[`CSR_ECFG_LIE]         = lie;
    estat_val[`CSR_ESTAT_IS]        = estat_is;
    estat_val[`CSR_ESTAT_ECODE]     = ecode;
    estat_val[`CSR_ESTAT_ESUBCODE]  = esubcode;
    eentry_val[`CSR_EENTRY_VA]      = eentry_va;
    tcfg_val[`CSR_TCFG_EN]          = tcfg_en;
    tcfg_val[`CSR_TCFG_PERIODIC]    = tcfg_periodic;
    tcfg_val[`CSR_TCFG_INITVAL]     = tcfg_initval;
  end

  // TICLR and unknown numbers fall to zero
  always_comb begin
    case (rd_sel)
      CSR_CRMD:   csr_rvalue = crmd_val;
      CSR_PRMD:   csr_rvalue = prmd_val;
      CSR_ECFG:   csr_rvalue = ecfg_val;
      CSR_ESTAT:  csr_rvalue = estat_val;
      CSR_ERA:    csr_rvalue = era;
      CSR_BADV:   csr_rvalue = badv;
      CSR_EENTRY: csr_rvalue = eentry_val;
      CSR_SAVE0:  csr_rvalue = save[0];
      CSR_SAVE1:  csr_rvalue = save[1];
      CSR_SAVE2:  csr_rvalue = save[2];
      CSR_SAVE3:  csr_rvalue = save[3];
      CSR_TCFG:   csr_rvalue = tcfg_val;
      CSR_TVAL:   csr_rvalue = tval;
      default:    csr_rvalue = '0;
    endcase
  end

endmodule

/* rtl/csr_top.sv */
`include "csr_defs.svh"

module csr_top import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`CSR_NUM_W-1:0]  csr_num,
  input  logic                   csr_we,
  input  logic [`CSR_DATA_W-1:0] csr_wmask,
  input  logic [`CSR_DATA_W-1:0] csr_wvalue,
  input  exc_info_t              exc,
  input  logic [7:0]             hw_int,
  output logic [`CSR_DATA_W-1:0] csr_rvalue,
  output logic                   has_int
);

  csr_write_t                   wr;
  csr_reg_e                     rd_sel;
  logic [1:0]                   plv;
  logic [1:0]                   pplv;
  logic                         ie;
  logic                         pie;
  logic [12:0]                  lie;
  logic [12:0]                  estat_is;
  ecode_e                       ecode;
  logic [8:0]                   esubcode;
  logic [`CSR_DATA_W-1:0]       era;
  logic [`CSR_DATA_W-1:0]       badv;
  logic [25:0]                  eentry_va;
  logic [3:0][`CSR_DATA_W-1:0]  save;
  logic                         tcfg_en;
  logic                         tcfg_periodic;
  logic [29:0]                  tcfg_initval;
  logic [`CSR_DATA_W-1:0]       tval;
  logic                         timer_is;

  csr_decode u_decode (
    .csr_num    (csr_num),
    .csr_we     (csr_we),
    .csr_wmask  (csr_wmask),
    .csr_wvalue (csr_wvalue),
    .wr         (wr),
    .rd_sel     (rd_sel)
  );

  csr_exc_regs u_exc_regs (
    .clk       (clk),
    .reset     (reset),
    .wr        (wr),
    .exc       (exc),
    .hw_int    (hw_int),
    .timer_is  (timer_is),
    .plv       (plv),
    .pplv      (pplv),
    .ie        (ie),
    .pie       (pie),
    .lie       (lie),
    .is_out    (estat_is),
    .ecode     (ecode),
    .esubcode  (esubcode),
    .era       (era),
    .badv      (badv),
    .eentry_va (eentry_va),
    .save      (save),
    .has_int   (has_int)
  );

  csr_timer u_timer (
    .clk           (clk),
    .reset         (reset),
    .wr            (wr),
    .tcfg_en       (tcfg_en),
    .tcfg_periodic (tcfg_periodic),
    .tcfg_initval  (tcfg_initval),
    .tval          (tval),
    .timer_is      (timer_is)
  );

  csr_read_mux u_read_mux (
    .rd_sel        (rd_sel),
    .plv           (plv),
    .pplv          (pplv),
    .ie            (ie),
    .pie           (pie),
    .lie           (lie),
    .estat_is      (estat_is),
    .ecode         (ecode),
    .esubcode      (esubcode),
    .era           (era),
    .badv          (badv),
    .eentry_va     (eentry_va),
    .save          (save),
    .tcfg_en       (tcfg_en),
    .tcfg_periodic (tcfg_periodic),
    .tcfg_initval  (tcfg_initval),
    .tval          (tval),
    .csr_rvalue    (csr_rvalue)
  );

endmodule

/* testbench/csr_tb.sv */
`include "csr_defs.svh"

module csr_tb import csr_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    PERIOD       = 4;
  localparam int    RESET_CYCLES = 10;
  localparam int    SLACK_CYCLES = 200;
  localparam string CASES_FILE   = "testbench/csr_cases.txt";

  localparam logic [39:0] KIND_WRITE = 40'("write");
  localparam logic [39:0] KIND_READ  = 40'("read");
  localparam logic [39:0] KIND_EXC   = 40'("exc");
  localparam logic [39:0] KIND_ERET  = 40'("eret");
  localparam logic [39:0] KIND_WAIT  = 40'("wait");
  localparam logic [39:0] KIND_IRQ   = 40'("irq");

  // One row of the case file
  typedef struct packed {
    logic [39:0]            kind;
    logic [`CSR_NUM_W-1:0]  num;
    logic [`CSR_DATA_W-1:0] mask;
    logic [`CSR_DATA_W-1:0] value;
    logic [`CSR_DATA_W-1:0] expected;
    logic [15:0]            cycles;
  } case_t;

  logic                   clk;
  logic                   reset;
  logic [`CSR_NUM_W-1:0]  csr_num;
  logic                   csr_we;
  logic [`CSR_DATA_W-1:0] csr_wmask;
  logic [`CSR_DATA_W-1:0] csr_wvalue;
  exc_info_t              exc;
  logic [7:0]             hw_int;
  logic [`CSR_DATA_W-1:0] csr_rvalue;
  logic                   has_int;

  case_t cases[$];
  int    errors;
  int    limit_cycles;

  csr_top UUT (
    .clk        (clk),
    .reset      (reset),
    .csr_num    (csr_num),
    .csr_we     (csr_we),
    .csr_wmask  (csr_wmask),
    .csr_wvalue (csr_wvalue),
    .exc        (exc),
    .hw_int     (hw_int),
    .csr_rvalue (csr_rvalue),
    .has_int    (has_int)
  );

  always #(PERIOD / 2) clk = ~clk;

  function automatic bit load_cases();
    int                     fd;
    int                     n;
    int                     cycles;
    string                  line;
    logic [39:0]            kind;
    logic [`CSR_NUM_W-1:0]  num;
    logic [`CSR_DATA_W-1:0] mask;
    logic [`CSR_DATA_W-1:0] value;
    logic [`CSR_DATA_W-1:0] expected;
    case_t                  c;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0)
      return 1'b0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %d", kind, num, mask, value, expected, cycles);
        if (n == 6) begin
          c.kind     = kind;
          c.num      = num;
          c.mask     = mask;
          c.value    = value;
          c.expected = expected;
          c.cycles   = cycles[15:0];
          cases.push_back(c);
        end else begin
          errors++;
          $display("Malformed line in case file: %s", line);
        end
      end
    end
    $fclose(fd);
    return cases.size() > 0;
  endfunction

  task automatic check_read(input logic [`CSR_NUM_W-1:0] num,
                            input logic [`CSR_DATA_W-1:0] expected);
    assert (csr_rvalue === expected)
    else begin
      errors++;
      $display("ERR csr_rvalue num=%h got=%h exp=%h", num, csr_rvalue, expected);
    end
  endtask

  task automatic check_has_int(input logic expected);
    assert (has_int === expected)
    else begin
      errors++;
      $display("ERR has_int hw_int=%h got=%h exp=%h", hw_int, has_int, expected);
    end
  endtask

  // Every case starts on a rising edge
  task automatic run_case(input case_t c);
    logic [`CSR_DATA_W-1:0] fill;
    @(posedge clk);
    csr_we <= 1'b0;
    exc    <= '0;
    case (c.kind)
      KIND_WRITE: begin
        fill = $urandom();
        csr_num    <= c.num;
        csr_we     <= 1'b1;
        csr_wmask  <= c.mask;
        csr_wvalue <= (c.mask & c.value) | (~c.mask & fill);
      end
      KIND_READ: begin
        csr_num <= c.num;
        @(negedge clk);
        check_read(c.num, c.expected);
      end
      KIND_EXC: begin
        exc.ex       <= 1'b1;
        exc.ecode    <= ecode_e'(c.num[5:0]);
        exc.esubcode <= c.mask[8:0];
        exc.pc       <= c.value;
        exc.vaddr    <= c.expected;
      end
      KIND_ERET: begin
        exc.eret <= 1'b1;
      end
      KIND_WAIT: begin
        repeat (int'(c.cycles) - 1) @(posedge clk);
      end
      KIND_IRQ: begin
        // Lines are sampled one edge later
        hw_int <= c.value[7:0];
        repeat (int'(c.cycles)) @(posedge clk);
        @(negedge clk);
        check_has_int(c.expected[0]);
      end
      default: begin
        errors++;
        $display("Unknown case kind in case file: %s", c.kind);
      end
    endcase
  endtask

  initial begin
    bit load_ok;
    int total;
    clk          = 1'b0;
    reset        = 1'b1;
    csr_num      = '0;
    csr_we       = 1'b0;
    csr_wmask    = '0;
    csr_wvalue   = '0;
    exc          = '0;
    hw_int       = 8'h00;
    errors       = 0;
    limit_cycles = 0;
    void'($urandom(32'h336e_e6ac));
    load_ok = load_cases();
    if (!load_ok) begin
      $display("Case file %s could not be read or holds no cases", CASES_FILE);
      $display("*** FAILED ***");
      $finish;
    end else begin
      total = 0;
      foreach (cases[i])
        total += int'(cases[i].cycles) + 1;
      limit_cycles = total + RESET_CYCLES + SLACK_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      foreach (cases[i])
        run_case(cases[i]);
      @(posedge clk);
      csr_we <= 1'b0;
      exc    <= '0;
      $display("Summary: %0d cases run, %0d errors", cases.size(), errors);
      if (errors == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the case list did not finish within %0d cycles", limit_cycles);
    $display("Summary: %0d cases loaded, %0d errors", cases.size(), errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* testbench/csr_cases.txt */
# kind   num   mask     value    expected cycles
# exc: num=ecode mask=esubcode value=pc expected=vaddr; irq: value=hw_int expected=has_int
read   0000 00000000 00000000 00000000 1
read   0004 00000000 00000000 00000000 1
read   0005 00000000 00000000 00000000 1
read   0042 00000000 00000000 ffffffff 1
irq    0000 00000000 00000000 00000000 1
write  0000 00000003 00000002 00000000 1
read   0000 00000000 00000000 00000002 1
write  0000 ffffffff fffffffd 00000000 1
read   0000 00000000 00000000 00000005 1
write  0001 00000004 00000004 00000000 1
read   0001 00000000 00000000 00000004 1
write  0004 ffffffff ffff0a5a 00000000 1
write  0004 0000000f 00000005 00000000 1
read   0004 00000000 00000000 00000a55 1
write  0006 ffffffff 89abcdef 00000000 1
write  0006 0000ffff 00001234 00000000 1
read   0006 00000000 00000000 89ab1234 1
write  000c ffffffff 1c008fff 00000000 1
read   000c 00000000 00000000 1c008fc0 1
write  0030 ffffffff 11111111 00000000 1
write  0031 ffffffff 22222222 00000000 1
write  0031 ff00ff00 aabbccdd 00000000 1
write  0032 ffffffff 33333333 00000000 1
write  0033 ffffffff 44444444 00000000 1
read   0030 00000000 00000000 11111111 1
read   0031 00000000 00000000 aa22cc22 1
read   0032 00000000 00000000 33333333 1
read   0033 00000000 00000000 44444444 1
write  0100 ffffffff 12345678 00000000 1
read   0100 00000000 00000000 00000000 1
read   0044 00000000 00000000 00000000 1
# Interrupt pending, LIE covers hw lines 0 and 1
write  0004 ffffffff 0000000c 00000000 1
irq    0000 00000000 00000001 00000001 1
irq    0000 00000000 00000004 00000000 1
read   0005 00000000 00000000 00000010 1
irq    0000 00000000 00000000 00000000 1
write  0005 00000003 00000002 00000000 1
irq    0000 00000000 00000000 00000000 1
write  0004 00000002 00000002 00000000 1
irq    0000 00000000 00000000 00000001 1
read   0005 00000000 00000000 00000002 1
write  0000 00000004 00000000 00000000 1
irq    0000 00000000 00000001 00000000 1
irq    0000 00000000 00000000 00000000 1
write  0005 00000003 00000000 00000000 1
write  0000 00000004 00000004 00000000 1
# One-shot timer, initval 3
write  0041 ffffffff 0000000d 00000000 1
read   0042 00000000 00000000 0000000c 1
wait   0000 00000000 00000000 00000000 11
read   0005 00000000 00000000 00000000 1
read   0005 00000000 00000000 00000800 1
read   0042 00000000 00000000 ffffffff 1
read   0041 00000000 00000000 0000000d 1
write  0044 00000001 00000001 00000000 1
read   0005 00000000 00000000 00000000 1
# Exception entry and return
write  0000 ffffffff 00000007 00000000 1
exc    0008 00000000 1c000100 deadbeef 1
read   0000 00000000 00000000 00000000 1
read   0001 00000000 00000000 00000007 1
read   0006 00000000 00000000 1c000100 1
read   0007 00000000 00000000 1c000100 1
read   0005 00000000 00000000 00080000 1
eret   0000 00000000 00000000 00000000 1
read   0000 00000000 00000000 00000007 1
exc    0009 00000000 1c000200 12345678 1
read   0007 00000000 00000000 12345678 1
read   0005 00000000 00000000 00090000 1
eret   0000 00000000 00000000 00000000 1
exc    000b 00000000 1c000300 cafef00d 1
read   0006 00000000 00000000 1c000300 1
read   0007 00000000 00000000 12345678 1
read   0005 00000000 00000000 000b0000 1
read   0001 00000000 00000000 00000007 1
eret   0000 00000000 00000000 00000000 1
read   0000 00000000 00000000 00000007 1

/* filelist.f */
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_exc_regs.sv
rtl/csr_timer.sv
rtl/csr_read_mux.sv
rtl/csr_top.sv
testbench/csr_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := csr_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) rtl/csr_defs.svh
CASES     := testbench/csr_cases.txt

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM) $(CASES)
	$(SIM) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
